/* filelist.f */
pi1_pkg.sv
litedram_pkg.sv
sync_fifo.sv
litedram_port_model.sv
pi1_to_litedram.sv
pi1_litedram_top.sv
tb_pi1_litedram.sv

/* run_sim.sh */
#!/bin/sh
# Build the PI1 LiteDRAM testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
	--top-module tb_pi1_litedram \
	-f filelist.f \
	-o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
	exit 1
fi
exit 0

/* tb_pi1_litedram.sv */
/* Testbench for the PI1 to LiteDRAM subsystem
   Shadow memory reference with a separate compare process */
`timescale 1ns/10ps

module tb_pi1_litedram import pi1_pkg::*, litedram_pkg::*; ();

	// Reads, writes, partial writes, swaps, random mix
	localparam int NUM_OPS = 8 + 32 + 32 + 16 + 300;
	localparam int MAX_CYCLES = 200 * NUM_OPS;

	logic                 clk_i;
	logic                 rst_n_i;
	logic                 refresh_busy_i;
	logic [1:0]           pi1_op_i;
	logic [ADDR_BITS-1:0] pi1_addr_i;
	logic [ARCH_BITS-1:0] pi1_data_i;
	logic [SEL_BITS-1:0]  pi1_sel_i;
	logic [ARCH_BITS-1:0] pi1_data_o;
	logic                 pi1_rdy_o;

	logic [ARCH_BITS-1:0] shadow [MEM_WORDS];
	logic [ADDR_BITS-1:0] addr_list [16];
	logic [ARCH_BITS-1:0] exp_data_q [$];
	logic [ADDR_BITS-1:0] exp_addr_q [$];
	event check_ev;
	int errors;
	int cycle_count;
	bit refresh_on;

	pi1_litedram_top pi1_litedram_top_inst (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.refresh_busy_i(refresh_busy_i),
		.pi1_op_i(pi1_op_i),
		.pi1_addr_i(pi1_addr_i),
		.pi1_data_i(pi1_data_i),
		.pi1_sel_i(pi1_sel_i),
		.pi1_data_o(pi1_data_o),
		.pi1_rdy_o(pi1_rdy_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #4 clk_i = ~clk_i;
	end

	// New word after a write under byte select
	function automatic logic [ARCH_BITS-1:0] merged_word(input logic [ARCH_BITS-1:0] old_word,
		input logic [ARCH_BITS-1:0] data, input logic [SEL_BITS-1:0] sel);
		logic [ARCH_BITS-1:0] result;
		result = old_word;
		for (int b = 0; b < SEL_BITS; b++) begin
			if (sel[b]) begin
				result[8*b +: 8] = data[8*b +: 8];
			end
		end
		return result;
	endfunction

	task automatic next_cycle();
		@(negedge clk_i);
		if (refresh_on) begin
			refresh_busy_i = ($urandom % 3 == 0);
		end
	endtask

	// Issue one operation and wait for pi1_rdy_o to come back
	task automatic run_op(input logic [1:0] op, input logic [ADDR_BITS-1:0] addr,
		input logic [ARCH_BITS-1:0] data, input logic [SEL_BITS-1:0] sel);
		int low_cycles;
		int min_low;
		logic [MEM_ADDR_BITS-1:0] idx;
		logic [ARCH_BITS-1:0] old_word;
		idx = addr[MEM_ADDR_BITS-1:0];
		old_word = shadow[idx];
		case (op)
			PI1_OP_WR: min_low = 1;
			PI1_OP_RD: min_low = 2;
			default: min_low = 3;
		endcase
		pi1_op_i = op;
		pi1_addr_i = addr;
		pi1_data_i = data;
		pi1_sel_i = sel;
		next_cycle();
		while (pi1_rdy_o) begin
			next_cycle();
		end
		pi1_op_i = PI1_OP_NOOP;
		low_cycles = 0;
		while (!pi1_rdy_o) begin
			low_cycles++;
			next_cycle();
		end
		if (low_cycles < min_low) begin
			$display("At %0t: pi1_rdy_o rose after %0d cycles with op %0d still outstanding",
				$time, low_cycles, op);
			errors++;
		end
		if (op != PI1_OP_RD) begin
			shadow[idx] = merged_word(old_word, data, sel);
		end
		if (op != PI1_OP_WR) begin
			exp_data_q.push_back(old_word);
			exp_addr_q.push_back(addr);
			-> check_ev;
		end
	endtask

	initial begin : compare_proc
		logic [ARCH_BITS-1:0] exp_word;
		logic [ADDR_BITS-1:0] exp_addr;
		forever begin
			@(check_ev);
			while (exp_data_q.size() > 0) begin
				exp_word = exp_data_q.pop_front();
				exp_addr = exp_addr_q.pop_front();
				if (pi1_data_o !== exp_word) begin
					$display("Mismatch at %0t: pi1_data_o addr 0x%08h expected 0x%08h actual 0x%08h",
						$time, exp_addr, exp_word, pi1_data_o);
					errors++;
				end
			end
		end
	end

	initial begin : watchdog
		cycle_count = 0;
		while (cycle_count < MAX_CYCLES) begin
			@(posedge clk_i);
			cycle_count++;
		end
		$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
		$display("Errors: %0d", errors + 1);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin : stimulus
		logic [ADDR_BITS-1:0] addr;
		logic [ARCH_BITS-1:0] data;
		logic [SEL_BITS-1:0] sel;
		logic [1:0] op;
		void'($urandom(46));
		errors = 0;
		refresh_on = 1'b0;
		rst_n_i = 1'b0;
		refresh_busy_i = 1'b0;
		pi1_op_i = PI1_OP_NOOP;
		pi1_addr_i = '0;
		pi1_data_i = '0;
		pi1_sel_i = '0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			shadow[i] = '0;
		end
		repeat (5) @(posedge clk_i);
		@(negedge clk_i);
		rst_n_i = 1'b1;
		next_cycle();

		// Idle after reset, memory reads back zero
		if (!pi1_rdy_o) begin
			$display("At %0t: pi1_rdy_o is low after reset", $time);
			errors++;
		end
		repeat (8) run_op(PI1_OP_RD, ADDR_BITS'($urandom), '0, '0);

		for (int i = 0; i < 16; i++) begin
			addr_list[i] = ADDR_BITS'($urandom);
			run_op(PI1_OP_WR, addr_list[i], $urandom, '1);
		end
		for (int i = 0; i < 16; i++) begin
			run_op(PI1_OP_RD, addr_list[i], '0, '0);
		end

		// Partial writes on top of known data
		for (int i = 0; i < 16; i++) begin
			run_op(PI1_OP_WR, addr_list[i], $urandom, SEL_BITS'($urandom));
		end
		for (int i = 0; i < 16; i++) begin
			run_op(PI1_OP_RD, addr_list[i], '0, '0);
		end

		for (int i = 0; i < 8; i++) begin
			run_op(PI1_OP_RW, addr_list[i], $urandom, SEL_BITS'($urandom));
		end
		for (int i = 0; i < 8; i++) begin
			run_op(PI1_OP_RD, addr_list[i], '0, '0);
		end

		// Random mix under refresh, few indexes so accesses collide
		refresh_on = 1'b1;
		repeat (300) begin
			addr = ADDR_BITS'($urandom);
			addr[MEM_ADDR_BITS-1:0] = MEM_ADDR_BITS'($urandom % 16);
			data = $urandom;
			sel = SEL_BITS'($urandom);
			case ($urandom % 3)
				0: op = PI1_OP_WR;
				1: op = PI1_OP_RD;
				default: op = PI1_OP_RW;
			endcase
			run_op(op, addr, data, sel);
		end
		refresh_on = 1'b0;
		refresh_busy_i = 1'b0;
		next_cycle();
		next_cycle();

		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

/* pi1_litedram_top.sv */
/* PI1 memory subsystem
   Bridge joined to the behavioral LiteDRAM port */
`timescale 1ns/10ps

module pi1_litedram_top import pi1_pkg::*; (
	input  logic                 clk_i,
	input  logic                 rst_n_i,
	input  logic                 refresh_busy_i,
	input  logic [1:0]           pi1_op_i,
	input  logic [ADDR_BITS-1:0] pi1_addr_i,
	input  logic [ARCH_BITS-1:0] pi1_data_i,
	input  logic [SEL_BITS-1:0]  pi1_sel_i,
	output logic [ARCH_BITS-1:0] pi1_data_o,
	output logic                 pi1_rdy_o
);

	logic cmd_valid;
	logic cmd_ready;
	logic cmd_we;
	logic [ADDR_BITS-1:0] cmd_addr;
	logic wdata_valid;
	logic wdata_ready;
	logic [SEL_BITS-1:0] wdata_we;
	logic [ARCH_BITS-1:0] wdata_data;
	logic rdata_valid;
	logic rdata_ready;
	logic [ARCH_BITS-1:0] rdata_data;

	pi1_to_litedram pi1_to_litedram_inst (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.pi1_op_i(pi1_op_i),
		.pi1_addr_i(pi1_addr_i),
		.pi1_data_i(pi1_data_i),
		.pi1_sel_i(pi1_sel_i),
		.cmd_ready_i(cmd_ready),
		.wdata_ready_i(wdata_ready),
		.rdata_valid_i(rdata_valid),
		.rdata_data_i(rdata_data),
		.pi1_data_o(pi1_data_o),
		.pi1_rdy_o(pi1_rdy_o),
		.cmd_valid_o(cmd_valid),
		.cmd_we_o(cmd_we),
		.cmd_addr_o(cmd_addr),
		.wdata_valid_o(wdata_valid),
		.wdata_we_o(wdata_we),
		.wdata_data_o(wdata_data),
		.rdata_ready_o(rdata_ready)
	);

	litedram_port_model litedram_port_model_inst (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.refresh_busy_i(refresh_busy_i),
		.cmd_valid_i(cmd_valid),
		.cmd_we_i(cmd_we),
		.cmd_addr_i(cmd_addr),
		.wdata_valid_i(wdata_valid),
		.wdata_we_i(wdata_we),
		.wdata_data_i(wdata_data),
		.rdata_ready_i(rdata_ready),
		.cmd_ready_o(cmd_ready),
		.wdata_ready_o(wdata_ready),
		.rdata_valid_o(rdata_valid),
		.rdata_data_o(rdata_data)
	);

endmodule

/* pi1_to_litedram.sv */
/* PI1 to LiteDRAM native port bridge
   Maps write, read and swap onto the command, write and read channels */
`timescale 1ns/10ps

module pi1_to_litedram import pi1_pkg::*; (
	input  logic                 clk_i,
	input  logic                 rst_n_i,
	input  logic [1:0]           pi1_op_i,
	input  logic [ADDR_BITS-1:0] pi1_addr_i,
	input  logic [ARCH_BITS-1:0] pi1_data_i,
	input  logic [SEL_BITS-1:0]  pi1_sel_i,
	input  logic                 cmd_ready_i,
	input  logic                 wdata_ready_i,
	input  logic                 rdata_valid_i,
	input  logic [ARCH_BITS-1:0] rdata_data_i,
	output logic [ARCH_BITS-1:0] pi1_data_o,
	output logic                 pi1_rdy_o,
	output logic                 cmd_valid_o,
	output logic                 cmd_we_o,
	output logic [ADDR_BITS-1:0] cmd_addr_o,
	output logic                 wdata_valid_o,
	output logic [SEL_BITS-1:0]  wdata_we_o,
	output logic [ARCH_BITS-1:0] wdata_data_o,
	output logic                 rdata_ready_o
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WRITE,
		ST_READ,
		ST_SWAP
	} state_t;

	state_t state_q;
	logic done_reading_q;
	logic rd_arrived;
	logic swap_issue;
	logic [SEL_BITS-1:0] swap_sel_q;
	logic [ARCH_BITS-1:0] swap_data_q;
	logic [ADDR_BITS-1:0] swap_addr_q;

	assign pi1_rdy_o = (state_q == ST_IDLE);
	assign rd_arrived = rdata_valid_i || done_reading_q;
	assign swap_issue = (state_q == ST_SWAP) && rd_arrived && cmd_ready_i;

	// Idle passes the PI1 command straight through
	assign cmd_valid_o = pi1_rdy_o ? (pi1_op_i != PI1_OP_NOOP)
		: ((state_q == ST_SWAP) && rd_arrived);
	assign cmd_we_o = pi1_rdy_o ? (pi1_op_i == PI1_OP_WR) : (state_q == ST_SWAP);
	assign cmd_addr_o = pi1_rdy_o ? pi1_addr_i : swap_addr_q;

	assign wdata_valid_o = (state_q == ST_WRITE);
	assign rdata_ready_o = 1'b1;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state_q <= ST_IDLE;
			done_reading_q <= 1'b0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (cmd_ready_i) begin
						case (pi1_op_i)
							PI1_OP_WR: state_q <= ST_WRITE;
							PI1_OP_RD: state_q <= ST_READ;
							PI1_OP_RW: state_q <= ST_SWAP;
							default: state_q <= ST_IDLE;
						endcase
						done_reading_q <= 1'b0;
					end
				end
				ST_WRITE: begin
					if (wdata_ready_i) begin
						state_q <= ST_IDLE;
					end
				end
				ST_READ: begin
					if (rdata_valid_i) begin
						state_q <= ST_IDLE;
						done_reading_q <= 1'b1;
					end
				end
				ST_SWAP: begin
					if (rdata_valid_i) begin
						done_reading_q <= 1'b1;
					end
					// Write half may stall behind refresh
					if (swap_issue) begin
						state_q <= ST_WRITE;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (pi1_rdy_o && cmd_ready_i && pi1_op_i == PI1_OP_WR) begin
			wdata_we_o <= pi1_sel_i;
			wdata_data_o <= pi1_data_i;
		end else if (swap_issue) begin
			wdata_we_o <= swap_sel_q;
			wdata_data_o <= swap_data_q;
		end
		if (pi1_rdy_o && cmd_ready_i && pi1_op_i == PI1_OP_RW) begin
			swap_sel_q <= pi1_sel_i;
			swap_data_q <= pi1_data_i;
			swap_addr_q <= pi1_addr_i;
		end
		// Only the first returned word is kept
		if ((state_q == ST_READ || state_q == ST_SWAP) && rdata_valid_i && !done_reading_q) begin
			pi1_data_o <= rdata_data_i;
		end
	end

	a_wready_with_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wdata_ready_i |-> wdata_valid_o);
	a_rdata_when_reading: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		rdata_valid_i |-> (state_q == ST_READ || state_q == ST_SWAP));

endmodule

/* litedram_port_model.sv */
/* Behavioral LiteDRAM native user port
   Queued commands, read return queue and a byte-enable word array */
`timescale 1ns/10ps

module litedram_port_model import pi1_pkg::*, litedram_pkg::*; (
	input  logic                 clk_i,
	input  logic                 rst_n_i,
	input  logic                 refresh_busy_i,
	input  logic                 cmd_valid_i,
	input  logic                 cmd_we_i,
	input  logic [ADDR_BITS-1:0] cmd_addr_i,
	input  logic                 wdata_valid_i,
	input  logic [SEL_BITS-1:0]  wdata_we_i,
	input  logic [ARCH_BITS-1:0] wdata_data_i,
	input  logic                 rdata_ready_i,
	output logic                 cmd_ready_o,
	output logic                 wdata_ready_o,
	output logic                 rdata_valid_o,
	output logic [ARCH_BITS-1:0] rdata_data_o
);

	ldram_cmd_t cmd_in;
	ldram_cmd_t cmd_head;
	logic cmd_push;
	logic cmd_pop;
	logic cmd_full;
	logic cmd_empty;
	logic head_rd;
	logic head_wr;
	logic rd_push;
	logic rd_pop;
	logic rd_full;
	logic rd_empty;
	logic [MEM_ADDR_BITS-1:0] head_idx;
	logic [ARCH_BITS-1:0] mem_q [MEM_WORDS];

	// Refresh holds off new commands
	assign cmd_ready_o = !cmd_full && !refresh_busy_i;
	assign cmd_push = cmd_valid_i && cmd_ready_o;
	assign cmd_in = '{we: cmd_we_i, addr: cmd_addr_i};

	sync_fifo #(
		.payload_t(ldram_cmd_t),
		.DEPTH(CMD_FIFO_DEPTH)
	) cmd_fifo_inst (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.push_i(cmd_push),
		.push_data_i(cmd_in),
		.pop_i(cmd_pop),
		.pop_data_o(cmd_head),
		.full_o(cmd_full),
		.empty_o(cmd_empty)
	);

	assign head_rd = !cmd_empty && !cmd_head.we;
	assign head_wr = !cmd_empty && cmd_head.we;
	assign head_idx = cmd_head.addr[MEM_ADDR_BITS-1:0];

	// Head read needs room in the return queue, head write needs data
	assign rd_push = head_rd && !rd_full;
	assign wdata_ready_o = head_wr && wdata_valid_i;
	assign cmd_pop = rd_push || wdata_ready_o;

	sync_fifo #(
		.payload_t(logic [ARCH_BITS-1:0]),
		.DEPTH(RD_FIFO_DEPTH)
	) rd_fifo_inst (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.push_i(rd_push),
		.push_data_i(mem_q[head_idx]),
		.pop_i(rd_pop),
		.pop_data_o(rdata_data_o),
		.full_o(rd_full),
		.empty_o(rd_empty)
	);

	assign rdata_valid_o = !rd_empty;
	assign rd_pop = rdata_valid_o && rdata_ready_i;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < MEM_WORDS; i++) begin
				mem_q[i] <= '0;
			end
		end else if (wdata_ready_o) begin
			for (int b = 0; b < SEL_BITS; b++) begin
				if (wdata_we_i[b]) begin
					mem_q[head_idx][8*b +: 8] <= wdata_data_i[8*b +: 8];
				end
			end
		end
	end

endmodule

/* sync_fifo.sv */
/* Synchronous FIFO, first-word fall-through
   Payload type and depth set by parameters */
`timescale 1ns/10ps

module sync_fifo #(
	parameter type payload_t = logic [31:0],
	parameter int DEPTH = 4
) (
	input  logic     clk_i,
	input  logic     rst_n_i,
	input  logic     push_i,
	input  payload_t push_data_i,
	input  logic     pop_i,
	output payload_t pop_data_o,
	output logic     full_o,
	output logic     empty_o
);

	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	payload_t slot_q [DEPTH];
	logic [PTR_BITS-1:0] rd_ptr_q;
	logic [PTR_BITS-1:0] wr_ptr_q;
	logic [CNT_BITS-1:0] count_q;
	logic do_push;
	logic do_pop;

	function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
		if (ptr == PTR_BITS'(DEPTH - 1)) begin
			return '0;
		end else begin
			return ptr + 1'b1;
		end
	endfunction

	assign full_o = (count_q == CNT_BITS'(DEPTH));
	assign empty_o = (count_q == '0);
	assign pop_data_o = slot_q[rd_ptr_q];
	assign do_push = push_i && !full_o;
	assign do_pop = pop_i && !empty_o;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			rd_ptr_q <= '0;
			wr_ptr_q <= '0;
			count_q <= '0;
		end else begin
			if (do_push) begin
				wr_ptr_q <= next_ptr(wr_ptr_q);
			end
			if (do_pop) begin
				rd_ptr_q <= next_ptr(rd_ptr_q);
			end
			case ({do_push, do_pop})
				2'b10: count_q <= count_q + 1'b1;
				2'b01: count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (do_push) begin
			slot_q[wr_ptr_q] <= push_data_i;
		end
	end

	// Producer and consumer must respect the flags
	a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		push_i |-> !full_o);
	a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		pop_i |-> !empty_o);

endmodule

/* litedram_pkg.sv */
/* LiteDRAM native port definitions
   Model memory size, queue depths and the queued command layout */
package litedram_pkg;

	import pi1_pkg::*;

	// Model array index, upper address bits ignored
	localparam int MEM_ADDR_BITS = 8;
	localparam int MEM_WORDS = 1 << MEM_ADDR_BITS;

	// Queue depths inside the port model
	localparam int CMD_FIFO_DEPTH = 4;
	localparam int RD_FIFO_DEPTH = 4;

	// Queued command
	typedef struct packed {
		logic we;
		logic [ADDR_BITS-1:0] addr;
	} ldram_cmd_t;

endpackage

/* pi1_pkg.sv */
/* PI1 bus definitions
   Word, select and address widths plus the operation codes */
package pi1_pkg;

	// Data word width
	localparam int ARCH_BITS = 32;

	// One select bit per byte lane
	localparam int SEL_BITS = ARCH_BITS / 8;

	// Word address, byte offset bits removed
	localparam int ADDR_BITS = ARCH_BITS - $clog2(SEL_BITS);

	// Operation codes
	localparam logic [1:0] PI1_OP_NOOP = 2'b00;
	localparam logic [1:0] PI1_OP_WR = 2'b01;
	localparam logic [1:0] PI1_OP_RD = 2'b10;
	localparam logic [1:0] PI1_OP_RW = 2'b11;

endpackage
